/* source/isa_pkg.sv */
`default_nettype none

package isa_pkg;

   typedef logic [7:0] word_t;                 // Data and address word

   // One nibble per instruction, high nibble of a byte first
   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,                          // r0 = r1 + r2
      OP_SUB  = 4'h1,                          // r0 = r1 - r2
      OP_MUL  = 4'h2,                          // r0 = low byte of r1 * r2
      OP_NAND = 4'h3,                          // r0 = ~(r1 & r2)
      OP_SW01 = 4'h4,                          // Swap r0 and r1
      OP_SW12 = 4'h5,                          // Swap r1 and r2
      OP_SW23 = 4'h6,                          // Swap r2 and r3
      OP_BE   = 4'h7,                          // pc = r3 if r1 == r2
      OP_LDW  = 4'hC,                          // r2 = mem[r3]
      OP_STW  = 4'hD,                          // mem[r3] = r2
      OP_REF  = 4'hE                           // r0 = mem[0]
   } opcode_t;

   typedef logic [1:0] reg_idx_t;              // r0 to r3

   localparam int unsigned MAP_REG_BIT = 8;    // Map address bit for register space

endpackage

`default_nettype wire

/* source/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

   typedef enum logic [3:0] {
      IDLE,
      LOAD_REGS,                               // Soft start, fills r0 to r3
      FETCH,
      DECODE,
      EXEC_1,
      EXEC_2,
      EXEC_3
   } seq_state_t;

   typedef enum logic [3:0] {
      BUS_LOAD_ADDR,
      BUS_FETCH_ADDR,
      BUS_PC_INC,
      BUS_ADD,
      BUS_SUB,
      BUS_MUL,
      BUS_NAND,
      BUS_X01,
      BUS_X12,
      BUS_X23,
      BUS_R2,
      BUS_R3,
      BUS_MEM,
      BUS_ZERO
   } bus_src_t;

   // Bit 2 set takes bus, clear takes memory; low bits pick the register
   typedef logic [2:0] rb_sel_t;

endpackage

`default_nettype wire

/* source/core_if.sv */
`default_nettype none

interface core_if;
   import isa_pkg::*;
   import ctrl_pkg::*;

   // Control from the sequencer
   bus_src_t   bus_src;
   reg_idx_t   load_idx;
   rb_sel_t    rb_sel;
   logic       rb_we;
   logic       ir_we;
   logic       pc_we;
   logic       ale;                            // Address latch enable
   logic       mem_we;

   // Datapath
   word_t      bus;
   word_t      mem_rd;                         // Byte at the address latch
   word_t      pc;                             // Nibble address
   opcode_t    opcode;
   logic       z;                              // r1 == r2
   word_t      r0;
   word_t      r1;
   word_t      r2;
   word_t      r3;

   modport seq   (output bus_src, load_idx, rb_sel, rb_we, ir_we, pc_we, ale, mem_we,
                  input  opcode, z);
   modport exec  (output bus,
                  input  bus_src, load_idx, mem_rd, pc, r0, r1, r2, r3);
   modport regs  (output z, r0, r1, r2, r3,
                  input  bus, mem_rd, rb_sel, rb_we);
   modport fetch (output pc, opcode,
                  input  bus, mem_rd, ir_we, pc_we);
   modport mem   (output mem_rd,
                  input  bus, ale, mem_we);

endinterface

`default_nettype wire

/* source/sequencer.sv */
`default_nettype none

module sequencer (
   input logic    clk,
   input logic    nRst,
   input logic    soft_start,
   core_if.seq    cif
);
   import isa_pkg::*;
   import ctrl_pkg::*;

   seq_state_t    state;
   logic [2:0]    load_cnt;                    // Five load cycles
   reg_idx_t      load_reg;
   logic          is_swap;
   logic          is_mem_op;

   assign cif.load_idx = load_cnt[1:0];
   assign load_reg     = load_cnt[1:0] - 2'd1; // Register filled by the previous latch

   assign is_swap   = (cif.opcode == OP_SW01) || (cif.opcode == OP_SW12) ||
                      (cif.opcode == OP_SW23);
   assign is_mem_op = (cif.opcode == OP_LDW) || (cif.opcode == OP_STW) ||
                      (cif.opcode == OP_REF);

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state    <= IDLE;                     // Wait for a soft start
         load_cnt <= '0;
      end else if (soft_start) begin
         state    <= LOAD_REGS;
         load_cnt <= '0;
      end else begin
         case (state)
            IDLE:      state <= IDLE;
            LOAD_REGS: begin
               load_cnt <= load_cnt + 3'd1;
               if (load_cnt == 3'd4)
                  state <= FETCH;
            end
            FETCH:     state <= DECODE;
            DECODE:    state <= EXEC_1;
            EXEC_1:    state <= (is_swap || is_mem_op) ? EXEC_2 : FETCH;
            EXEC_2:    state <= is_swap ? EXEC_3 : FETCH;
            EXEC_3:    state <= FETCH;
            default:   state <= IDLE;
         endcase
      end
   end

   always_comb begin
      cif.bus_src = BUS_ZERO;
      cif.rb_sel  = 3'd4;                      // r0 from bus
      cif.rb_we   = 1'b0;
      cif.ir_we   = 1'b0;
      cif.pc_we   = 1'b0;
      cif.ale     = 1'b0;
      cif.mem_we  = 1'b0;
      case (state)
         LOAD_REGS: begin
            cif.ale     = 1'b1;
            cif.bus_src = (load_cnt == 3'd4) ? BUS_FETCH_ADDR : BUS_LOAD_ADDR;
            if (load_cnt != 3'd0) begin
               cif.rb_sel = {1'b0, load_reg};  // From memory
               cif.rb_we  = 1'b1;
            end
         end
         FETCH: begin
            cif.bus_src = BUS_FETCH_ADDR;
            cif.ale     = 1'b1;
         end
         DECODE: begin
            cif.bus_src = BUS_PC_INC;
            cif.ir_we   = 1'b1;
            cif.pc_we   = 1'b1;
         end
         EXEC_1: begin
            case (cif.opcode)
               OP_ADD:  begin cif.bus_src = BUS_ADD;  cif.rb_we = 1'b1; end
               OP_SUB:  begin cif.bus_src = BUS_SUB;  cif.rb_we = 1'b1; end
               OP_MUL:  begin cif.bus_src = BUS_MUL;  cif.rb_we = 1'b1; end
               OP_NAND: begin cif.bus_src = BUS_NAND; cif.rb_we = 1'b1; end
               OP_SW01: begin cif.bus_src = BUS_X01;  cif.rb_we = 1'b1; end
               OP_SW12: begin
                  cif.bus_src = BUS_X12;
                  cif.rb_sel  = 3'd5;
                  cif.rb_we   = 1'b1;
               end
               OP_SW23: begin
                  cif.bus_src = BUS_X23;
                  cif.rb_sel  = 3'd6;
                  cif.rb_we   = 1'b1;
               end
               OP_BE: begin
                  cif.bus_src = BUS_R3;
                  cif.pc_we   = cif.z;         // Taken only on equal
               end
               OP_LDW, OP_STW: begin
                  cif.bus_src = BUS_R3;
                  cif.ale     = 1'b1;
               end
               OP_REF:  cif.ale = 1'b1;        // Latch address 0
               default: ;                      // Dropped opcodes
            endcase
         end
         EXEC_2: begin
            case (cif.opcode)
               OP_SW01: begin
                  cif.bus_src = BUS_X01;
                  cif.rb_sel  = 3'd5;
                  cif.rb_we   = 1'b1;
               end
               OP_SW12: begin
                  cif.bus_src = BUS_X12;
                  cif.rb_sel  = 3'd6;
                  cif.rb_we   = 1'b1;
               end
               OP_SW23: begin
                  cif.bus_src = BUS_X23;
                  cif.rb_sel  = 3'd7;
                  cif.rb_we   = 1'b1;
               end
               OP_LDW: begin
                  cif.bus_src = BUS_MEM;
                  cif.rb_sel  = 3'd6;          // r2 from bus
                  cif.rb_we   = 1'b1;
               end
               OP_STW: begin
                  cif.bus_src = BUS_R2;
                  cif.mem_we  = 1'b1;
               end
               OP_REF: begin
                  cif.rb_sel = 3'd0;           // r0 from memory
                  cif.rb_we  = 1'b1;
               end
               default: ;
            endcase
         end
         EXEC_3: begin
            cif.rb_we = 1'b1;                  // Last XOR of a swap
            case (cif.opcode)
               OP_SW12: begin cif.bus_src = BUS_X12; cif.rb_sel = 3'd5; end
               OP_SW23: begin cif.bus_src = BUS_X23; cif.rb_sel = 3'd6; end
               default: cif.bus_src = BUS_X01;
            endcase
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* source/exec_unit.sv */
`default_nettype none

module exec_unit (
   core_if.exec   cif
);
   import isa_pkg::*;
   import ctrl_pkg::*;

   word_t   fetch_addr;

   assign fetch_addr = {1'b0, cif.pc[7:1]};    // Two nibbles per byte

   always_comb begin
      case (cif.bus_src)
         BUS_LOAD_ADDR:  cif.bus = {6'd0, cif.load_idx};
         BUS_FETCH_ADDR: cif.bus = fetch_addr;
         BUS_PC_INC:     cif.bus = cif.pc + 8'd1;
         BUS_ADD:        cif.bus = cif.r1 + cif.r2;
         BUS_SUB:        cif.bus = cif.r1 - cif.r2;
         BUS_MUL:        cif.bus = cif.r1 * cif.r2;  // Low byte only
         BUS_NAND:       cif.bus = ~(cif.r1 & cif.r2);
         BUS_X01:        cif.bus = cif.r0 ^ cif.r1;
         BUS_X12:        cif.bus = cif.r1 ^ cif.r2;
         BUS_X23:        cif.bus = cif.r2 ^ cif.r3;
         BUS_R2:         cif.bus = cif.r2;
         BUS_R3:         cif.bus = cif.r3;
         BUS_MEM:        cif.bus = cif.mem_rd;
         default:        cif.bus = '0;
      endcase
   end

endmodule

`default_nettype wire

/* source/reg_file.sv */
`default_nettype none

module reg_file (
   input logic                clk,
   input logic                nRst,
   core_if.regs               cif,
   input isa_pkg::reg_idx_t   map_sel,
   output isa_pkg::word_t     map_reg
);
   import isa_pkg::*;

   word_t   regs [4];

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         regs <= '{default: '0};
      end else if (cif.rb_we) begin
         if (cif.rb_sel[2])
            regs[cif.rb_sel[1:0]] <= cif.bus;
         else
            regs[cif.rb_sel[1:0]] <= cif.mem_rd;
      end
   end

   assign cif.r0  = regs[0];
   assign cif.r1  = regs[1];
   assign cif.r2  = regs[2];
   assign cif.r3  = regs[3];
   assign cif.z   = (regs[1] == regs[2]);      // Branch condition
   assign map_reg = regs[map_sel];

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`default_nettype none

module fetch_unit #(
   parameter isa_pkg::word_t PC_START = 8'd8
) (
   input logic    clk,
   input logic    nRst,
   core_if.fetch  cif
);
   import isa_pkg::*;

   word_t      pc;
   opcode_t    ir;
   logic [3:0] nibble;

   assign nibble = cif.pc[0] ? cif.mem_rd[3:0] : cif.mem_rd[7:4];  // High nibble first

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= PC_START;
         ir <= OP_ADD;
      end else begin
         if (cif.pc_we)
            pc <= cif.bus;
         if (cif.ir_we)
            ir <= opcode_t'(nibble);
      end
   end

   assign cif.pc     = pc;
   assign cif.opcode = ir;

endmodule

`default_nettype wire

/* source/data_mem.sv */
`default_nettype none

module data_mem (
   input logic             clk,
   core_if.mem             cif,
   input logic             map_load,
   input logic [8:0]       map_addr,
   input isa_pkg::word_t   map_in,
   input isa_pkg::word_t   map_reg,
   output isa_pkg::word_t  map_out,
   output logic            soft_start
);
   import isa_pkg::*;

   word_t   mem [256];
   word_t   addr;                              // Address latch
   logic    map_wr;

   assign soft_start = map_load & map_addr[MAP_REG_BIT];
   assign map_wr     = map_load & ~map_addr[MAP_REG_BIT];

   always_ff @(posedge clk) begin
      if (cif.ale)
         addr <= cif.bus;
      if (cif.mem_we)
         mem[addr] <= cif.bus;
      if (map_wr)
         mem[map_addr[7:0]] <= map_in;         // Map port wins on a clash
   end

   assign cif.mem_rd = mem[addr];
   assign map_out    = map_addr[MAP_REG_BIT] ? map_reg : mem[map_addr[7:0]];

endmodule

`default_nettype wire

/* source/up_core.sv */
`default_nettype none

module up_core #(
   parameter isa_pkg::word_t PC_START = 8'd8
) (
   input logic             clk,
   input logic             nRst,
   input logic             mem_map_load,
   input logic [8:0]       mem_map_address,    // Bit 8 selects r0 to r3
   input isa_pkg::word_t   mem_map_in,
   output isa_pkg::word_t  mem_map_out
);
   import isa_pkg::*;

   logic    soft_start;
   word_t   map_reg;

   core_if cif ();

   sequencer u_sequencer (
      .clk        (clk),
      .nRst       (nRst),
      .soft_start (soft_start),
      .cif        (cif.seq)
   );

   exec_unit u_exec_unit (
      .cif        (cif.exec)
   );

   reg_file u_reg_file (
      .clk        (clk),
      .nRst       (nRst),
      .cif        (cif.regs),
      .map_sel    (mem_map_address[1:0]),
      .map_reg    (map_reg)
   );

   fetch_unit #(
      .PC_START   (PC_START)
   ) u_fetch_unit (
      .clk        (clk),
      .nRst       (nRst),
      .cif        (cif.fetch)
   );

   data_mem u_data_mem (
      .clk        (clk),
      .cif        (cif.mem),
      .map_load   (mem_map_load),
      .map_addr   (mem_map_address),
      .map_in     (mem_map_in),
      .map_reg    (map_reg),
      .map_out    (mem_map_out),
      .soft_start (soft_start)
   );

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`default_nettype none

module clock_gen #(
   parameter int PERIOD = 100
) (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

endmodule

`default_nettype wire

/* bench/sequencer_assertions.sv */
`default_nettype none

module sequencer_assertions (
   input logic                   clk,
   input logic                   nRst,
   input logic                   soft_start,
   input ctrl_pkg::seq_state_t   state,
   input logic                   ir_we,
   input logic                   pc_we,
   input logic                   mem_we
);
   timeunit 1ns;
   timeprecision 100ps;
   import ctrl_pkg::*;

   int fail_count = 0;                         // Read by the testbench at the end

   store_not_branch: assert property (@(posedge clk) disable iff (!nRst) !(mem_we && pc_we))
   else begin
      $error("mem_we and pc_we set in the same cycle");
      fail_count++;
   end

   ir_in_decode: assert property (@(posedge clk) disable iff (!nRst) ir_we |-> state == DECODE)
   else begin
      $error("ir_we set outside DECODE");
      fail_count++;
   end

   // Core stays idle out of reset until a soft start
   idle_after_reset: assert property (@(posedge clk) disable iff (!nRst)
      $rose(nRst) |-> state == IDLE)
   else begin
      $error("state not IDLE after reset");
      fail_count++;
   end

   idle_holds: assert property (@(posedge clk) disable iff (!nRst)
      (state == IDLE && !soft_start) |=> state == IDLE)
   else begin
      $error("left IDLE without a soft start");
      fail_count++;
   end

endmodule

`default_nettype wire

/* bench/up_core_tb.sv */
`default_nettype none

module up_core_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import isa_pkg::*;
   import ctrl_pkg::*;

   localparam word_t PC_START   = 8'd8;
   localparam int    CODE_BASE  = PC_START / 2;   // First code byte
   localparam int    CODE_BYTES = 40;
   localparam int    N_INSTR    = 24;
   localparam int    N_RUNS     = 8;
   localparam int    WATCHDOG_CYCLES = 40 + 100 +
                        N_RUNS * (8 + CODE_BYTES + 10 + 5 * N_INSTR);

   logic          clk;
   logic          nRst;
   logic          mem_map_load;
   logic [8:0]    mem_map_address;
   word_t         mem_map_in;
   word_t         mem_map_out;

   word_t         mdl_mem [256];                 // ISA model state
   word_t         mdl_r [4];
   word_t         mdl_pc;
   logic          stored;
   word_t         store_addr;
   logic [31:0]   rng = 32'hffc;
   int            errors = 0;
   int            checks = 0;
   int            tests = 0;
   int            errors_at_start;
   int            checks_at_start;

   clock_gen u_clock_gen (.clk(clk));

   up_core #(.PC_START(PC_START)) UUT (
      .clk             (clk),
      .nRst            (nRst),
      .mem_map_load    (mem_map_load),
      .mem_map_address (mem_map_address),
      .mem_map_in      (mem_map_in),
      .mem_map_out     (mem_map_out)
   );

   bind sequencer sequencer_assertions u_seq_assertions (
      .clk(clk), .nRst(nRst), .soft_start(soft_start), .state(state),
      .ir_we(cif.ir_we), .pc_we(cif.pc_we), .mem_we(cif.mem_we)
   );

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic logic [3:0] pick_op(input logic [15:0] mask);
      logic [3:0] op;
      do
         op = 4'(next_rand() >> 8);
      while (!mask[op]);
      return op;
   endfunction

   // Runs one instruction on the model and returns its cycle count
   function automatic int model_exec();
      word_t      code;
      logic [3:0] op;
      word_t      t;
      int         cycles;
      code   = mdl_mem[{1'b0, mdl_pc[7:1]}];
      op     = mdl_pc[0] ? code[3:0] : code[7:4];
      mdl_pc = mdl_pc + 8'd1;
      cycles = 3;
      stored = 1'b0;
      case (op)
         OP_ADD:  mdl_r[0] = mdl_r[1] + mdl_r[2];
         OP_SUB:  mdl_r[0] = mdl_r[1] - mdl_r[2];
         OP_MUL:  mdl_r[0] = mdl_r[1] * mdl_r[2];
         OP_NAND: mdl_r[0] = ~(mdl_r[1] & mdl_r[2]);
         OP_SW01, OP_SW12, OP_SW23: begin
            t            = mdl_r[op - 4];
            mdl_r[op - 4] = mdl_r[op - 3];
            mdl_r[op - 3] = t;
            cycles       = 5;
         end
         OP_BE: begin
            if (mdl_r[1] == mdl_r[2])
               mdl_pc = mdl_r[3];
         end
         OP_LDW: begin
            mdl_r[2] = mdl_mem[mdl_r[3]];
            cycles   = 4;
         end
         OP_STW: begin
            mdl_mem[mdl_r[3]] = mdl_r[2];
            store_addr        = mdl_r[3];
            stored            = 1'b1;
            cycles            = 4;
         end
         OP_REF: begin
            mdl_r[0] = mdl_mem[0];
            cycles   = 4;
         end
         default: ;                                // Dropped opcodes do nothing
      endcase
      return cycles;
   endfunction

   task automatic step();
      @(posedge clk);
      #10;
   endtask

   task automatic map_write(input logic [8:0] addr, input word_t data);
      mem_map_address = addr;
      mem_map_in      = data;
      mem_map_load    = 1'b1;
      if (!addr[MAP_REG_BIT])
         mdl_mem[addr[7:0]] = data;
      step();
      mem_map_load    = 1'b0;
   endtask

   task automatic check_map(input logic [8:0] addr, input word_t expected, input string what);
      mem_map_address = addr;
      #1;
      checks++;
      assert (mem_map_out === expected)
      else begin
         $display("CHECK FAILED at %0d ns: %s at map address %h reads %h, expected %h",
                  $time, what, addr, mem_map_out, expected);
         errors++;
      end
   endtask

   task automatic check_boundary();
      checks++;
      assert (UUT.u_sequencer.state == FETCH)
      else begin
         $display("CHECK FAILED at %0d ns: sequencer state %0d at an instruction boundary",
                  $time, UUT.u_sequencer.state);
         errors++;
      end
   endtask

   task automatic reset_core();
      nRst = 1'b0;
      repeat (4) step();
      nRst   = 1'b1;
      mdl_pc = PC_START;
   endtask

   task automatic load_program(input logic [15:0] mask, input word_t r3, input logic equal12);
      word_t r1;
      int    b;
      reset_core();
      r1 = 8'(next_rand());
      map_write(9'h000, 8'(next_rand()));
      map_write(9'h001, r1);
      map_write(9'h002, equal12 ? r1 : 8'(next_rand()));
      map_write(9'h003, r3);
      for (b = CODE_BASE; b < CODE_BASE + CODE_BYTES; b++)
         map_write(9'(b), {pick_op(mask), pick_op(mask)});
   endtask

   task automatic start_core();
      int k;
      map_write(9'h100, 8'h00);                    // Soft start
      repeat (5) step();
      for (k = 0; k < 4; k++)
         mdl_r[k] = mdl_mem[k];
      check_boundary();
   endtask

   task automatic run_instrs(input int n);
      int i;
      int cycles;
      for (i = 0; i < n; i++) begin
         cycles = model_exec();
         repeat (cycles) step();
         check_boundary();
         if (stored)
            check_map({1'b0, store_addr}, mdl_mem[store_addr], "stored byte");
         else
            check_map({1'b1, 6'd0, 2'(i)}, mdl_r[i % 4], "register");
      end
   endtask

   task automatic begin_test();
      errors_at_start = errors;
      checks_at_start = checks;
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("Test %0d %s: %0d checks, %0d errors", tests, name,
               checks - checks_at_start, errors - errors_at_start);
   endtask

   initial begin
      int i;
      nRst            = 1'b0;
      mem_map_load    = 1'b0;
      mem_map_address = '0;
      mem_map_in      = '0;
      reset_core();

      begin_test();
      for (i = 0; i < 16; i++)
         map_write(9'h080 + 9'(i), 8'(next_rand()));   // Data area for LDW and STW
      for (i = 0; i < 16; i++) begin
         check_map(9'h080 + 9'(i), mdl_mem[8'h80 + 8'(i)], "memory byte");
         step();
      end
      end_test("map port");

      begin_test();
      load_program(16'h8000, 8'(next_rand()), 1'b0);
      start_core();
      for (i = 0; i < 4; i++) begin
         check_map(9'h100 + 9'(i), mdl_mem[i], "register");
         step();
      end
      end_test("soft start");

      begin_test();
      load_program(16'h007F, 8'(next_rand()), 1'b0);
      start_core();
      run_instrs(N_INSTR);
      end_test("arithmetic and swaps");

      for (i = 0; i < 3; i++) begin
         begin_test();
         load_program(16'h7019, 8'h80 | 8'(next_rand() & 32'hF), 1'b0);
         start_core();
         run_instrs(N_INSTR);
         end_test("memory access");
      end

      for (i = 0; i < 2; i++) begin
         begin_test();
         load_program(16'h00BB, PC_START + 8'd2 + 8'(next_rand() % 40), i == 0);
         map_write(9'(CODE_BASE), {OP_BE, OP_ADD});     // Branch comes first
         start_core();
         run_instrs(N_INSTR);
         end_test(i == 0 ? "branch taken" : "branch not taken");
      end

      begin_test();
      load_program(16'h8F00, 8'(next_rand()), 1'b0);
      start_core();
      run_instrs(12);
      end_test("dropped opcodes");

      $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests, checks,
               errors, UUT.u_sequencer.u_seq_assertions.fail_count);
      if (errors == 0 && UUT.u_sequencer.u_seq_assertions.fail_count == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired, run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
source/isa_pkg.sv
source/ctrl_pkg.sv
source/core_if.sv
source/sequencer.sv
source/exec_unit.sv
source/reg_file.sv
source/fetch_unit.sv
source/data_mem.sv
source/up_core.sv
bench/clock_gen.sv
bench/sequencer_assertions.sv
bench/up_core_tb.sv
